//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_bus_subsystem -f vlog.f
	@out="$$(./obj_dir/Vtb_bus_subsystem)"; echo "$$out"; \
		echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps --top-module bus_subsystem \
		bus_pkg.sv core_bus_front.sv memory_port.sv io_port.sv bus_subsystem.sv

clean:
	rm -rf obj_dir

//--- bus_pkg.sv
// Bus subsystem shared definitions

package bus_pkg;

	// Address width of core port and both buses
	localparam int unsigned ADDR_W = 32;

	// Core side data width
	localparam int unsigned DATA_W = 32;

	// Memory return line width
	localparam int unsigned LINE_W = 64;

	// Lanes per memory line in each view
	localparam int unsigned LINE_WORDS = LINE_W / 32;
	localparam int unsigned LINE_HALVES = LINE_W / 16;
	localparam int unsigned LINE_BYTES = LINE_W / 8;

	// Access size, same code on core port and memory bus
	typedef enum logic [1:0] {
		// Single byte
		ORDER_BYTE = 2'd0,
		// Two bytes
		ORDER_HALF = 2'd1,
		// Full word
		ORDER_WORD = 2'd2,
		// No access, refused
		ORDER_NONE = 2'd3
	} order_t;

	// Memory return line seen as words, halves or bytes
	// Lane 0 sits at the low bits, little endian
	typedef union packed {
		logic [LINE_WORDS-1:0][31:0] words;
		logic [LINE_HALVES-1:0][15:0] halves;
		logic [LINE_BYTES-1:0][7:0] bytes;
	} mem_line_t;

endpackage

//--- bus_subsystem.sv
// Processor bus subsystem top
`timescale 1ns/1ps

module bus_subsystem #(
	parameter logic [bus_pkg::ADDR_W-1:0] IO_BASE = 32'hFFFF_0000
) (
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Core port
	input logic req,
	output logic ack,
	input logic rw,
	input bus_pkg::order_t order,
	input logic [bus_pkg::ADDR_W-1:0] addr,
	input logic [bus_pkg::DATA_W-1:0] wdata,
	output logic [bus_pkg::DATA_W-1:0] rdata,
	output logic error,
	// Memory bus
	output logic memory_req,
	input logic memory_lock,
	output bus_pkg::order_t memory_order,
	output logic memory_rw,
	output logic [bus_pkg::ADDR_W-1:0] memory_addr,
	output logic [bus_pkg::DATA_W-1:0] memory_data,
	input logic memory_valid,
	input logic [bus_pkg::LINE_W-1:0] memory_rdata,
	// GCI bus
	output logic gci_req,
	input logic gci_busy,
	output logic gci_rw,
	output logic [bus_pkg::ADDR_W-1:0] gci_addr,
	output logic [bus_pkg::DATA_W-1:0] gci_data,
	input logic gci_return,
	input logic [bus_pkg::DATA_W-1:0] gci_rdata
);

	// Held access, shared by both ports
	logic acc_rw;
	bus_pkg::order_t acc_order;
	logic [bus_pkg::ADDR_W-1:0] acc_addr;
	logic [bus_pkg::DATA_W-1:0] acc_wdata;
	// Start and done per port
	logic mem_start;
	logic mem_done;
	logic [bus_pkg::DATA_W-1:0] mem_rdata;
	logic mem_error;
	logic io_start;
	logic io_done;
	logic [bus_pkg::DATA_W-1:0] io_rdata;
	logic io_error;

	core_bus_front #(
		.IO_BASE(IO_BASE)
	) u_front (
		.iBUS_CLOCK(iBUS_CLOCK), .inRESET(inRESET),
		.req(req), .ack(ack), .rw(rw), .order(order), .addr(addr), .wdata(wdata),
		.rdata(rdata), .error(error),
		.mem_start(mem_start), .io_start(io_start),
		.acc_rw(acc_rw), .acc_order(acc_order), .acc_addr(acc_addr), .acc_wdata(acc_wdata),
		.mem_done(mem_done), .mem_rdata(mem_rdata), .mem_error(mem_error),
		.io_done(io_done), .io_rdata(io_rdata), .io_error(io_error)
	);

	memory_port u_memory_port (
		.iBUS_CLOCK(iBUS_CLOCK), .inRESET(inRESET),
		.start(mem_start), .rw(acc_rw), .order(acc_order), .addr(acc_addr), .wdata(acc_wdata),
		.done(mem_done), .rdata(mem_rdata), .error(mem_error),
		.memory_req(memory_req), .memory_lock(memory_lock), .memory_order(memory_order),
		.memory_rw(memory_rw), .memory_addr(memory_addr), .memory_data(memory_data),
		.memory_valid(memory_valid), .memory_rdata(memory_rdata)
	);

	io_port u_io_port (
		.iBUS_CLOCK(iBUS_CLOCK), .inRESET(inRESET),
		.start(io_start), .rw(acc_rw), .order(acc_order), .addr(acc_addr), .wdata(acc_wdata),
		.done(io_done), .rdata(io_rdata), .error(io_error),
		.gci_req(gci_req), .gci_busy(gci_busy), .gci_rw(gci_rw),
		.gci_addr(gci_addr), .gci_data(gci_data),
		.gci_return(gci_return), .gci_rdata(gci_rdata)
	);

endmodule

//--- core_bus_front.sv
// Core port handshake and address steering
`timescale 1ns/1ps

module core_bus_front #(
	parameter logic [bus_pkg::ADDR_W-1:0] IO_BASE = 32'hFFFF_0000
) (
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Core side, four phase
	input logic req,
	output logic ack,
	input logic rw,
	input bus_pkg::order_t order,
	input logic [bus_pkg::ADDR_W-1:0] addr,
	input logic [bus_pkg::DATA_W-1:0] wdata,
	output logic [bus_pkg::DATA_W-1:0] rdata,
	output logic error,
	// Port starts and held access
	output logic mem_start,
	output logic io_start,
	output logic acc_rw,
	output bus_pkg::order_t acc_order,
	output logic [bus_pkg::ADDR_W-1:0] acc_addr,
	output logic [bus_pkg::DATA_W-1:0] acc_wdata,
	// Port replies
	input logic mem_done,
	input logic [bus_pkg::DATA_W-1:0] mem_rdata,
	input logic mem_error,
	input logic io_done,
	input logic [bus_pkg::DATA_W-1:0] io_rdata,
	input logic io_error
);

	// Handshake states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BUSY = 2'd1;
	localparam logic [1:0] ST_ACK = 2'd2;

	logic [1:0] state;
	logic start_q;
	logic sel_io;
	logic port_done;

	// Only the started port may finish
	assign port_done = sel_io ? io_done : mem_done;

	// One start, steered by the latched decode
	assign mem_start = start_q & ~sel_io;
	assign io_start = start_q & sel_io;

	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
			start_q <= 1'b0;
			sel_io <= 1'b0;
			ack <= 1'b0;
			error <= 1'b0;
		end else begin
			// Start lasts one cycle
			start_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Req level is enough, it was low when ack fell
					if (req) begin
						sel_io <= (addr >= IO_BASE);
						start_q <= 1'b1;
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (port_done) begin
						error <= sel_io ? io_error : mem_error;
						ack <= 1'b1;
						state <= ST_ACK;
					end
				end
				ST_ACK: begin
					// Hold ack until the core lets go of req
					if (!req) begin
						ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Request latch and reply data
	always_ff @(posedge iBUS_CLOCK) begin
		if (state == ST_IDLE && req) begin
			acc_rw <= rw;
			acc_order <= order;
			acc_addr <= addr;
			acc_wdata <= wdata;
		end
		if (state == ST_BUSY && port_done) begin
			rdata <= sel_io ? io_rdata : mem_rdata;
		end
	end

endmodule

//--- io_port.sv
// GCI peripheral bus port
`timescale 1ns/1ps

module io_port (
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Access from the front
	input logic start,
	input logic rw,
	input bus_pkg::order_t order,
	input logic [bus_pkg::ADDR_W-1:0] addr,
	input logic [bus_pkg::DATA_W-1:0] wdata,
	output logic done,
	output logic [bus_pkg::DATA_W-1:0] rdata,
	output logic error,
	// GCI request and return
	output logic gci_req,
	input logic gci_busy,
	output logic gci_rw,
	output logic [bus_pkg::ADDR_W-1:0] gci_addr,
	output logic [bus_pkg::DATA_W-1:0] gci_data,
	input logic gci_return,
	input logic [bus_pkg::DATA_W-1:0] gci_rdata
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ = 2'd1;
	localparam logic [1:0] ST_READ = 2'd2;

	logic [1:0] state;
	// Write acknowledge, one cycle after acceptance
	logic wr_ack;

	// GCI has no order lines, only word access gets here
	assign gci_rw = rw;
	assign gci_addr = addr;
	assign gci_data = wdata;

	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
			gci_req <= 1'b0;
			wr_ack <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			done <= 1'b0;
			wr_ack <= 1'b0;
			// Write completion, no return from the device
			if (wr_ack) begin
				done <= 1'b1;
				error <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					if (start) begin
						// Alignment fault, IO is word only
						if (order != bus_pkg::ORDER_WORD) begin
							done <= 1'b1;
							error <= 1'b1;
						end else begin
							gci_req <= 1'b1;
							state <= ST_REQ;
						end
					end
				end
				ST_REQ: begin
					if (!gci_busy) begin
						gci_req <= 1'b0;
						wr_ack <= rw;
						state <= rw ? ST_IDLE : ST_READ;
					end
				end
				ST_READ: begin
					if (gci_return) begin
						done <= 1'b1;
						error <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Read data from the return pulse
	always_ff @(posedge iBUS_CLOCK) begin
		if (state == ST_READ && gci_return) begin
			rdata <= gci_rdata;
		end else if (start) begin
			rdata <= '0;
		end
	end

endmodule

//--- memory_port.sv
// External memory bus port
`timescale 1ns/1ps

module memory_port (
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Access from the front
	input logic start,
	input logic rw,
	input bus_pkg::order_t order,
	input logic [bus_pkg::ADDR_W-1:0] addr,
	input logic [bus_pkg::DATA_W-1:0] wdata,
	output logic done,
	output logic [bus_pkg::DATA_W-1:0] rdata,
	output logic error,
	// Memory bus
	output logic memory_req,
	input logic memory_lock,
	output bus_pkg::order_t memory_order,
	output logic memory_rw,
	output logic [bus_pkg::ADDR_W-1:0] memory_addr,
	output logic [bus_pkg::DATA_W-1:0] memory_data,
	input logic memory_valid,
	input logic [bus_pkg::LINE_W-1:0] memory_rdata
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;

	logic [1:0] state;
	bus_pkg::mem_line_t line;
	logic [bus_pkg::DATA_W-1:0] lane;

	// Front holds these until done, so they stay stable under req
	assign memory_order = order;
	assign memory_rw = rw;
	assign memory_addr = addr;
	assign memory_data = wdata;

	assign line = memory_rdata;

	// Lane pick out of the aligned line, zero extended
	always_comb begin
		lane = '0;
		case (order)
			bus_pkg::ORDER_BYTE: lane[7:0] = line.bytes[addr[2:0]];
			bus_pkg::ORDER_HALF: lane[15:0] = line.halves[addr[2:1]];
			bus_pkg::ORDER_WORD: lane[31:0] = line.words[addr[2]];
			default: lane = '0;
		endcase
	end

	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
			memory_req <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						// Order none never reaches the bus
						if (order == bus_pkg::ORDER_NONE) begin
							done <= 1'b1;
							error <= 1'b1;
						end else begin
							memory_req <= 1'b1;
							state <= ST_REQ;
						end
					end
				end
				ST_REQ: begin
					// Accepted in the first cycle without lock
					if (!memory_lock) begin
						memory_req <= 1'b0;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					// Valid answers reads and writes alike
					if (memory_valid) begin
						done <= 1'b1;
						error <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Read lane capture, writes return zero
	always_ff @(posedge iBUS_CLOCK) begin
		if (state == ST_WAIT && memory_valid) begin
			rdata <= rw ? '0 : lane;
		end else if (start) begin
			rdata <= '0;
		end
	end

endmodule

//--- tb_bus_checker.sv
// Bus subsystem reply checker
`timescale 1ns/1ps

module tb_bus_checker #(
	parameter logic [bus_pkg::ADDR_W-1:0] IO_BASE = 32'hFFFF_0000
) (
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Core port
	input logic req,
	input logic ack,
	input logic rw,
	input bus_pkg::order_t order,
	input logic [bus_pkg::ADDR_W-1:0] addr,
	input logic [bus_pkg::DATA_W-1:0] wdata,
	input logic [bus_pkg::DATA_W-1:0] rdata,
	input logic error,
	// Bus requests, their stall lines and request fields
	input logic memory_req,
	input logic memory_lock,
	input bus_pkg::order_t memory_order,
	input logic memory_rw,
	input logic [bus_pkg::ADDR_W-1:0] memory_addr,
	input logic [bus_pkg::DATA_W-1:0] memory_data,
	input logic gci_req,
	input logic gci_busy,
	input logic gci_rw,
	input logic [bus_pkg::ADDR_W-1:0] gci_addr,
	input logic [bus_pkg::DATA_W-1:0] gci_data,
	// Tallies for the closing line
	output int error_count,
	output int check_count
);

	// Shadow memory lines and GCI registers
	logic [63:0] mem_shadow [16];
	logic [31:0] io_shadow [16];
	// Access being tracked
	logic cur_rw;
	bus_pkg::order_t cur_order;
	logic [31:0] cur_addr;
	logic [31:0] cur_wdata;
	logic cur_io;
	logic in_flight;
	logic accepted;
	logic ack_prev;
	logic req_prev;
	logic [32:0] expected;

	// Size-selected bytes at the low address bits
	function automatic logic [63:0] shadow_merge(input logic [63:0] line,
			input bus_pkg::order_t o, input logic [2:0] offset, input logic [31:0] data);
		logic [63:0] merged;
		merged = line;
		case (o)
			bus_pkg::ORDER_BYTE: merged[{offset, 3'b000} +: 8] = data[7:0];
			bus_pkg::ORDER_HALF: merged[{offset[2:1], 4'b0000} +: 16] = data[15:0];
			bus_pkg::ORDER_WORD: merged[{offset[2], 5'b00000} +: 32] = data;
			default: merged = line;
		endcase
		return merged;
	endfunction

	// Expected {error, rdata} for one access
	function automatic logic [32:0] expected_reply(input logic w, input bus_pkg::order_t o,
			input logic [31:0] a, input logic [63:0] line, input logic [31:0] io_word);
		if (a >= IO_BASE) begin
			// IO is word only
			if (o != bus_pkg::ORDER_WORD) return {1'b1, 32'h0};
			return w ? 33'h0 : {1'b0, io_word};
		end
		if (o == bus_pkg::ORDER_NONE) return {1'b1, 32'h0};
		if (w) return 33'h0;
		case (o)
			bus_pkg::ORDER_BYTE: return {1'b0, 24'h0, line[{a[2:0], 3'b000} +: 8]};
			bus_pkg::ORDER_HALF: return {1'b0, 16'h0, line[{a[2:1], 4'b0000} +: 16]};
			default: return {1'b0, line[{a[2], 5'b00000} +: 32]};
		endcase
	endfunction

	task automatic report_fault(input string what);
		$display("Protocol fault at %0t ns: %s", $time, what);
		error_count++;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("ERROR %s at addr %h: got %h, expected %h", name, cur_addr, got, want);
		error_count++;
	endtask

	// Sampled on the rising edge, before the DUT registers move
	always @(posedge iBUS_CLOCK) begin
		if (!inRESET) begin
			for (int i = 0; i < 16; i++) begin
				mem_shadow[i] = '0;
				io_shadow[i] = '0;
			end
			error_count = 0;
			check_count = 0;
			in_flight = 1'b0;
			accepted = 1'b0;
			ack_prev = 1'b0;
			req_prev = 1'b0;
		end else begin
			// New access on rising req
			if (req && !req_prev) begin
				cur_rw = rw;
				cur_order = order;
				cur_addr = addr;
				cur_wdata = wdata;
				cur_io = (addr >= IO_BASE);
				in_flight = 1'b1;
				accepted = 1'b0;
			end
			if (memory_req) begin
				if (!in_flight || cur_io || cur_order == bus_pkg::ORDER_NONE) begin
					report_fault($sformatf("memory_req high for an access at %h that must not use it",
						cur_addr));
				end else if (!memory_lock) begin
					accepted = 1'b1;
					// Bus fields carry the core request
					if (memory_order !== cur_order) begin
						report_mismatch("memory_order", {30'h0, memory_order}, {30'h0, cur_order});
					end
					if (memory_rw !== cur_rw) begin
						report_mismatch("memory_rw", {31'h0, memory_rw}, {31'h0, cur_rw});
					end
					if (memory_addr !== cur_addr) report_mismatch("memory_addr", memory_addr, cur_addr);
					if (cur_rw && memory_data !== cur_wdata) begin
						report_mismatch("memory_data", memory_data, cur_wdata);
					end
					if (cur_rw) begin
						mem_shadow[cur_addr[6:3]] = shadow_merge(mem_shadow[cur_addr[6:3]],
							cur_order, cur_addr[2:0], cur_wdata);
					end
				end
			end
			if (gci_req) begin
				if (!in_flight || !cur_io || cur_order != bus_pkg::ORDER_WORD) begin
					report_fault($sformatf("gci_req high for an access at %h that must not use it",
						cur_addr));
				end else if (!gci_busy) begin
					accepted = 1'b1;
					if (gci_rw !== cur_rw) report_mismatch("gci_rw", {31'h0, gci_rw}, {31'h0, cur_rw});
					if (gci_addr !== cur_addr) report_mismatch("gci_addr", gci_addr, cur_addr);
					if (cur_rw && gci_data !== cur_wdata) begin
						report_mismatch("gci_data", gci_data, cur_wdata);
					end
					if (cur_rw) io_shadow[cur_addr[5:2]] = cur_wdata;
				end
			end
			// Reply on rising ack
			if (ack && !ack_prev) begin
				if (!in_flight) begin
					report_fault("ack rose with no access in flight");
				end else begin
					expected = expected_reply(cur_rw, cur_order, cur_addr,
						mem_shadow[cur_addr[6:3]], io_shadow[cur_addr[5:2]]);
					check_count++;
					if (rdata !== expected[31:0]) report_mismatch("rdata", rdata, expected[31:0]);
					if (error !== expected[32]) begin
						report_mismatch("error", {31'h0, error}, {31'h0, expected[32]});
					end
					if (!expected[32] && !accepted) begin
						report_fault($sformatf("ack rose before the bus accepted access at %h",
							cur_addr));
					end
					in_flight = 1'b0;
				end
			end
			if (!ack && ack_prev && req_prev) report_fault("ack fell while req was still high");
			ack_prev = ack;
			req_prev = req;
		end
	end

endmodule

//--- tb_bus_subsystem.sv
// Bus subsystem testbench
`timescale 1ns/1ps

module tb_bus_subsystem;

	localparam logic [31:0] IO_BASE = 32'hFFFF_0000;
	localparam int DIRECTED_ACCESSES = 43;
	localparam int RANDOM_ACCESSES = 300;
	// Generous bound per access plus reset and drain
	localparam int TIMEOUT_CYCLES = (DIRECTED_ACCESSES + RANDOM_ACCESSES) * 64 + 200;

	logic iBUS_CLOCK;
	logic inRESET;
	logic req;
	logic ack;
	logic rw;
	bus_pkg::order_t order;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic error;
	logic memory_req;
	logic memory_lock;
	bus_pkg::order_t memory_order;
	logic memory_rw;
	logic [31:0] memory_addr;
	logic [31:0] memory_data;
	logic memory_valid;
	logic [63:0] memory_rdata;
	logic gci_req;
	logic gci_busy;
	logic gci_rw;
	logic [31:0] gci_addr;
	logic [31:0] gci_data;
	logic gci_return;
	logic [31:0] gci_rdata;

	// Device state
	logic [63:0] mem_lines [16];
	logic [31:0] gci_regs [16];
	logic mem_accept = 1'b0;
	logic io_accept = 1'b0;
	int error_count;
	int check_count;
	int issued = 0;
	int cycle_count = 0;
	int total_errors;

	bus_subsystem #(.IO_BASE(IO_BASE)) UUT (.*);

	tb_bus_checker #(.IO_BASE(IO_BASE)) u_checker (
		.iBUS_CLOCK(iBUS_CLOCK), .inRESET(inRESET),
		.req(req), .ack(ack), .rw(rw), .order(order), .addr(addr), .wdata(wdata),
		.rdata(rdata), .error(error),
		.memory_req(memory_req), .memory_lock(memory_lock), .memory_order(memory_order),
		.memory_rw(memory_rw), .memory_addr(memory_addr), .memory_data(memory_data),
		.gci_req(gci_req), .gci_busy(gci_busy), .gci_rw(gci_rw), .gci_addr(gci_addr),
		.gci_data(gci_data),
		.error_count(error_count), .check_count(check_count)
	);

	always #2 iBUS_CLOCK = ~iBUS_CLOCK;

	// Run limit
	always @(posedge iBUS_CLOCK) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Bus acceptance as seen by the devices
	always @(posedge iBUS_CLOCK) begin
		mem_accept <= memory_req & ~memory_lock;
		io_accept <= gci_req & ~gci_busy;
	end

	function automatic logic [63:0] merge_write(input logic [63:0] line,
			input bus_pkg::order_t o, input logic [2:0] offset, input logic [31:0] data);
		logic [63:0] merged;
		merged = line;
		case (o)
			bus_pkg::ORDER_BYTE: merged[{offset, 3'b000} +: 8] = data[7:0];
			bus_pkg::ORDER_HALF: merged[{offset[2:1], 4'b0000} +: 16] = data[15:0];
			bus_pkg::ORDER_WORD: merged[{offset[2], 5'b00000} +: 32] = data;
			default: merged = line;
		endcase
		return merged;
	endfunction

	// Memory model, random lock and valid delay
	initial begin
		memory_lock = 1'b0;
		memory_valid = 1'b0;
		memory_rdata = '0;
		for (int i = 0; i < 16; i++) mem_lines[i] = '0;
		forever begin
			@(negedge iBUS_CLOCK);
			memory_valid = 1'b0;
			memory_lock = ($urandom % 4) == 0;
			if (mem_accept) begin
				if (memory_rw) begin
					mem_lines[memory_addr[6:3]] = merge_write(mem_lines[memory_addr[6:3]],
						memory_order, memory_addr[2:0], memory_data);
				end
				repeat ($urandom % 4) @(negedge iBUS_CLOCK);
				memory_valid = 1'b1;
				memory_rdata = mem_lines[memory_addr[6:3]];
			end
		end
	end

	// GCI device, random busy and return delay
	initial begin
		gci_busy = 1'b0;
		gci_return = 1'b0;
		gci_rdata = '0;
		for (int i = 0; i < 16; i++) gci_regs[i] = '0;
		forever begin
			@(negedge iBUS_CLOCK);
			gci_return = 1'b0;
			gci_busy = ($urandom % 3) == 0;
			if (io_accept) begin
				if (gci_rw) begin
					gci_regs[gci_addr[5:2]] = gci_data;
				end else begin
					repeat ($urandom % 4) @(negedge iBUS_CLOCK);
					gci_return = 1'b1;
					gci_rdata = gci_regs[gci_addr[5:2]];
				end
			end
		end
	end

	// One four-phase access, core may hold req after ack
	task automatic run_access(input logic w, input bus_pkg::order_t o, input logic [31:0] a,
			input logic [31:0] d);
		@(negedge iBUS_CLOCK);
		req = 1'b1;
		rw = w;
		order = o;
		addr = a;
		wdata = d;
		@(negedge iBUS_CLOCK);
		while (!ack) @(negedge iBUS_CLOCK);
		repeat ($urandom % 3) @(negedge iBUS_CLOCK);
		req = 1'b0;
		@(negedge iBUS_CLOCK);
		while (ack) @(negedge iBUS_CLOCK);
		issued++;
	endtask

	function automatic logic [31:0] align_addr(input logic [31:0] a, input bus_pkg::order_t o);
		if (o == bus_pkg::ORDER_HALF) return a & ~32'h1;
		if (o == bus_pkg::ORDER_WORD) return a & ~32'h3;
		return a;
	endfunction

	task automatic run_random_mix(input int count);
		logic w;
		logic [1:0] pick;
		bus_pkg::order_t o;
		logic [31:0] a;
		for (int n = 0; n < count; n++) begin
			w = 1'($urandom);
			pick = 2'($urandom);
			o = bus_pkg::order_t'(pick);
			if ($urandom % 4 == 0) begin
				// IO window, mostly word
				a = IO_BASE | ($urandom & 32'h0000_FFFF);
				if ($urandom % 4 != 0) o = bus_pkg::ORDER_WORD;
			end else begin
				a = $urandom & 32'h0FFF_FFFF;
			end
			run_access(w, o, align_addr(a, o), $urandom);
		end
	endtask

	initial begin
		void'($urandom(53));
		iBUS_CLOCK = 1'b0;
		inRESET = 1'b0;
		req = 1'b0;
		rw = 1'b0;
		order = bus_pkg::ORDER_WORD;
		addr = '0;
		wdata = '0;
		repeat (4) @(negedge iBUS_CLOCK);
		inRESET = 1'b1;
		// Memory writes, words then halves then bytes
		run_access(1'b1, bus_pkg::ORDER_WORD, 32'h0000_0000, 32'h8899_AABB);
		run_access(1'b1, bus_pkg::ORDER_WORD, 32'h0000_0004, 32'hF1E2_D3C4);
		for (int i = 0; i < 4; i++) begin
			run_access(1'b1, bus_pkg::ORDER_HALF, 32'h8 + 32'(2 * i), 32'hDEAD_80A1 + 32'(i * 257));
		end
		for (int i = 0; i < 8; i++) begin
			run_access(1'b1, bus_pkg::ORDER_BYTE, 32'h10 + 32'(i), 32'h1234_5691 + 32'(i * 37));
		end
		// Reads over every byte offset
		for (int i = 0; i < 8; i++) run_access(1'b0, bus_pkg::ORDER_BYTE, 32'(i), 32'h0);
		for (int i = 0; i < 4; i++) begin
			run_access(1'b0, bus_pkg::ORDER_HALF, 32'h10 + 32'(2 * i), 32'h0);
		end
		run_access(1'b0, bus_pkg::ORDER_WORD, 32'h0000_0008, 32'h0);
		run_access(1'b0, bus_pkg::ORDER_WORD, 32'h0000_000C, 32'h0);
		// Order none stays off the bus
		run_access(1'b0, bus_pkg::ORDER_NONE, 32'h0000_0020, 32'h0);
		run_access(1'b1, bus_pkg::ORDER_NONE, 32'h0000_0020, 32'h5555_AAAA);
		// IO round trip
		for (int i = 0; i < 4; i++) begin
			run_access(1'b1, bus_pkg::ORDER_WORD, IO_BASE + 32'(4 * i), 32'hA5A5_0000 + 32'(i));
		end
		for (int i = 0; i < 4; i++) begin
			run_access(1'b0, bus_pkg::ORDER_WORD, IO_BASE + 32'(4 * i), 32'h0);
		end
		run_access(1'b1, bus_pkg::ORDER_WORD, IO_BASE + 32'h3C, 32'h0BAD_F00D);
		run_access(1'b0, bus_pkg::ORDER_WORD, IO_BASE + 32'h3C, 32'h0);
		// Alignment faults on IO
		run_access(1'b0, bus_pkg::ORDER_BYTE, IO_BASE + 32'h1, 32'h0);
		run_access(1'b1, bus_pkg::ORDER_HALF, IO_BASE + 32'h2, 32'h0000_1234);
		run_access(1'b1, bus_pkg::ORDER_BYTE, IO_BASE + 32'h4, 32'h0000_0077);
		run_random_mix(RANDOM_ACCESSES);
		repeat (4) @(negedge iBUS_CLOCK);
		total_errors = error_count;
		if (check_count != issued) begin
			$display("Checker compared %0d replies but %0d accesses were issued",
				check_count, issued);
			total_errors++;
		end
		$display("Accesses %0d, replies checked %0d, errors %0d", issued, check_count,
			total_errors);
		if (total_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
bus_pkg.sv
core_bus_front.sv
memory_port.sv
io_port.sv
bus_subsystem.sv
tb_bus_checker.sv
tb_bus_subsystem.sv
